/* Bender.yml */
package:
  name: sv32_mmu

sources:
  - files:
      - verilog/mmu_pkg.sv
      - verilog/tlb_array.sv
      - verilog/page_table_walker.sv
      - verilog/mmu_translator.sv
      - verilog/sv32_mmu.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/sv32_mmu_properties.sv
      - verif/sv32_mmu_tb.sv

/* list.f */
verilog/mmu_pkg.sv
verilog/tlb_array.sv
verilog/page_table_walker.sv
verilog/mmu_translator.sv
verilog/sv32_mmu.sv
verif/tb_clock_gen.sv
verif/sv32_mmu_properties.sv
verif/sv32_mmu_tb.sv

/* verif/sv32_mmu_properties.sv */
`timescale 1ns/1ps

module sv32_mmu_properties (
  input logic                 clk,
  input logic                 reset_n,
  input logic                 req_valid,
  input mmu_pkg::mmu_req_t    req,
  input mmu_pkg::satp_t       satp,
  input logic                 resp_ready,
  input logic                 resp_page_fault,
  input logic                 mem_req_valid,
  input logic [31:0]          mem_req_addr,
  input logic                 mem_resp_valid,
  input mmu_pkg::walk_state_t walker_state
);
  import mmu_pkg::*;

  int unsigned protocol_errors = 0;  // failure tally
  logic        bare;

  assign bare = !satp.mode || (req.priv == priv_machine);  // pa = va

  // ============================================================
  // memory port
  // ============================================================
  assert property (@(posedge clk) disable iff (!reset_n)
                   mem_req_valid && !mem_resp_valid |=> mem_req_valid && $stable(mem_req_addr))
    else begin
      $error("memory request dropped or its address changed before the response");
      protocol_errors++;
    end

  assert property (@(posedge clk) disable iff (!reset_n)
                   req_valid && bare |-> !mem_req_valid)  // no walk in bare mode
    else begin
      $error("memory request made for a bare mode translation");
      protocol_errors++;
    end

  // ============================================================
  // response side
  // ============================================================
  assert property (@(posedge clk) disable iff (!reset_n) resp_ready |=> !resp_ready)
    else begin
      $error("resp_ready stayed high for more than one cycle");
      protocol_errors++;
    end

  assert property (@(posedge clk) disable iff (!reset_n) resp_page_fault |-> resp_ready)
    else begin
      $error("page fault flagged without resp_ready");
      protocol_errors++;
    end

  // first edge after release still sees reset values
  assert property (@(posedge clk)
                   $rose(reset_n) |-> !resp_ready && !resp_page_fault && !mem_req_valid &&
                                      (walker_state == walk_idle))
    else begin
      $error("outputs not low or walker not idle coming out of reset");
      protocol_errors++;
    end

endmodule

bind sv32_mmu sv32_mmu_properties props_i (
  .clk             (clk),
  .reset_n         (reset_n),
  .req_valid       (req_valid),
  .req             (req),
  .satp            (satp),
  .resp_ready      (resp_ready),
  .resp_page_fault (resp_page_fault),
  .mem_req_valid   (mem_req_valid),
  .mem_req_addr    (mem_req_addr),
  .mem_resp_valid  (mem_resp_valid),
  .walker_state    (walker_i.state)
);

/* verif/sv32_mmu_tb.sv */
`timescale 1ns/1ps

module sv32_mmu_tb;
  import mmu_pkg::*;

  logic        clk;
  logic        reset_n;
  logic        req_valid;
  mmu_req_t    req;
  logic        resp_ready;
  logic [31:0] resp_paddr;
  logic        resp_page_fault;
  logic [31:0] resp_fault_vaddr;
  satp_t       satp;
  logic        sum;
  logic        mxr;
  logic        tlb_flush_all;
  logic        tlb_flush_page;
  logic [31:0] tlb_flush_vaddr;
  logic        mem_req_valid;
  logic [31:0] mem_req_addr;
  logic        mem_resp_valid;
  pte_t        mem_resp_data;

  logic [31:0] pte_mem [logic [31:0]];  // page table model, byte address -> pte
  int          mem_reads;                // reads served for the current request
  int          errors = 0;
  int unsigned request_count = 32;       // requests in the sequence below
  string       test_name;
  logic        exp_fault;
  logic [31:0] exp_paddr;
  logic [31:0] cur_vaddr;
  int          exp_reads;
  logic        exp_fast;                 // bare or tlb hit, one cycle

  tb_clock_gen clock_i (.clk(clk), .reset_n(reset_n));

  sv32_mmu dut_i (.*);

  // ============================================================
  // page table model
  // ============================================================
  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // valid leaf with a and d set
  function automatic logic [7:0] leaf_flags(input logic u, input logic x, input logic w,
                                            input logic r);
    return {2'b11, 1'b0, u, x, w, r, 1'b1};
  endfunction

  function automatic logic [31:0] read_pte(input logic [31:0] addr);
    if (pte_mem.exists(addr)) return pte_mem[addr];
    return 32'h0;  // unmapped reads as invalid
  endfunction

  function automatic logic [31:0] page_va(input logic [9:0] vpn1, input logic [9:0] vpn0);
    return {vpn1, vpn0, 12'($urandom)};  // random page offset
  endfunction

  // reference translation straight from the sv32 rules
  function automatic void model_translate(input logic [31:0] va, input access_t acc,
                                          input priv_t pv, output logic fault,
                                          output logic [31:0] pa);
    pte_t pte;
    logic mega;
    logic leaf_ok;
    logic priv_ok;
    logic need;
    fault = 1'b0;
    pa    = va;
    if (!satp.mode || (pv == priv_machine)) return;
    mega = 1'b1;
    pte  = pte_t'(read_pte({satp.ppn[19:0], 12'h000} + {20'h0, va[31:22], 2'b00}));
    if (pte.v && !pte.r && !pte.x) begin  // pointer to level 0
      mega = 1'b0;
      pte  = pte_t'(read_pte({pte.ppn1[9:0], pte.ppn0, 12'h000} + {20'h0, va[21:12], 2'b00}));
    end
    leaf_ok = pte.v && (pte.r || pte.x) && !(pte.w && !pte.r);
    priv_ok = (pv == priv_user) ? pte.u : (!pte.u || sum);
    case (acc)
      access_store: need = pte.w;
      access_fetch: need = pte.x;
      default:      need = pte.r || (pte.x && mxr);
    endcase
    fault = !(leaf_ok && priv_ok && need);
    pa    = mega ? {pte.ppn1[9:0], va[21:0]} : {pte.ppn1[9:0], pte.ppn0, va[11:0]};
  endfunction

  task automatic build_tables();
    pte_mem[32'h0010_0004] = make_pte(22'h00101, 8'h01);                     // vpn1 1, table
    pte_mem[32'h0010_0008] = make_pte(22'h01000, leaf_flags(0, 1, 1, 1));   // vpn1 2, megapage
    pte_mem[32'h0010_000c] = make_pte(22'h00102, 8'h01);                     // vpn1 3, table
    pte_mem[32'h0010_1000] = make_pte(22'h00200, leaf_flags(0, 0, 1, 1));   // rw
    pte_mem[32'h0010_1004] = make_pte(22'h00201, leaf_flags(0, 0, 0, 1));   // read only
    pte_mem[32'h0010_1008] = make_pte(22'h00202, leaf_flags(0, 1, 0, 0));   // x only
    pte_mem[32'h0010_100c] = make_pte(22'h00203, leaf_flags(1, 1, 1, 1));   // user rwx
    pte_mem[32'h0010_2000] = make_pte(22'h00103, 8'h01);  // pointer at level 0
    for (int i = 5; i < 14; i++) begin
      pte_mem[32'h0010_1000 + 32'(i * 4)] = make_pte(22'h00300 + 22'(i), leaf_flags(0, 0, 1, 1));
    end
  endtask

  // memory answers after 0 to 3 cycles
  initial forever begin
    int delay;
    @(posedge clk);
    #1;
    if (mem_req_valid) begin
      delay = $urandom_range(3);
      repeat (delay) @(posedge clk);
      if (delay > 0) #1;
      mem_resp_valid = 1'b1;
      mem_resp_data  = pte_t'(read_pte(mem_req_addr));
      mem_reads++;
      @(posedge clk);
      #1;
      mem_resp_valid = 1'b0;
    end
  end

  // ============================================================
  // response checks
  // ============================================================
  assert property (@(posedge clk) disable iff (!reset_n) resp_ready |-> resp_page_fault == exp_fault)
    else begin
      $display("FAILED %s: expected fault %0b, actual %0b", test_name, exp_fault,
               $sampled(resp_page_fault));
      errors++;
    end

  assert property (@(posedge clk) disable iff (!reset_n)
                   resp_ready && !exp_fault |-> resp_paddr == exp_paddr)
    else begin
      $display("FAILED %s: expected paddr %h, actual %h", test_name, exp_paddr, resp_paddr);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!reset_n)
                   resp_ready && exp_fault |-> resp_fault_vaddr == cur_vaddr)
    else begin
      $display("FAILED %s: expected fault vaddr %h, actual %h", test_name, cur_vaddr,
               resp_fault_vaddr);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!reset_n) resp_ready |-> mem_reads == exp_reads)
    else begin
      $display("FAILED %s: expected %0d memory reads, actual %0d", test_name, exp_reads, mem_reads);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!reset_n) $rose(req_valid) && exp_fast |=> resp_ready)
    else begin
      $display("FAILED %s: expected resp_ready 1 one cycle after req_valid, actual 0", test_name);
      errors++;
    end

  // ============================================================
  // stimulus
  // ============================================================
  task automatic translate(input string name, input logic [31:0] va, input access_t acc,
                           input priv_t pv, input int reads);
    logic        fault;
    logic [31:0] pa;
    model_translate(va, acc, pv, fault, pa);
    test_name = name;
    exp_fault = fault;
    exp_paddr = pa;
    exp_reads = reads;
    exp_fast  = (reads == 0);
    cur_vaddr = va;
    mem_reads = 0;
    req       = '{vaddr: va, access: acc, priv: pv};
    req_valid = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!resp_ready);
    req_valid = 1'b0;  // dropped in the pulse cycle
    @(posedge clk);
    #1;
  endtask

  task automatic flush_all_tlb();
    tlb_flush_all = 1'b1;
    @(posedge clk);
    #1;
    tlb_flush_all = 1'b0;
  endtask

  task automatic flush_tlb_page(input logic [31:0] va);
    tlb_flush_page  = 1'b1;
    tlb_flush_vaddr = va;
    @(posedge clk);
    #1;
    tlb_flush_page = 1'b0;
  endtask

  initial begin : watchdog
    repeat (request_count * 40) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", request_count * 40);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [31:0] first_va;
    void'($urandom(32'h5b22_638c));
    req_valid       = 1'b0;
    req             = '0;
    satp            = '0;
    sum             = 1'b0;
    mxr             = 1'b0;
    tlb_flush_all   = 1'b0;
    tlb_flush_page  = 1'b0;
    tlb_flush_vaddr = '0;
    mem_resp_valid  = 1'b0;
    mem_resp_data   = '0;
    exp_fast        = 1'b0;
    build_tables();
    @(posedge reset_n);
    @(posedge clk);
    #1;

    translate("bare_satp_off", $urandom, access_load, priv_supervisor, 0);
    satp = '{mode: 1'b1, asid: 9'd0, ppn: 22'h00100};
    translate("bare_machine", page_va(4, 7), access_store, priv_machine, 0);  // unmapped page

    // walks, then hits
    translate("walk_4k", page_va(1, 0), access_load, priv_supervisor, 2);
    translate("walk_mega", page_va(2, 10'($urandom)), access_load, priv_supervisor, 1);
    translate("hit_4k", page_va(1, 0), access_store, priv_supervisor, 0);
    translate("hit_mega", page_va(2, 10'($urandom)), access_fetch, priv_supervisor, 0);

    // ============================================================
    // permission faults
    // ============================================================
    translate("invalid_l1", page_va(4, 0), access_load, priv_supervisor, 1);
    translate("invalid_l0", page_va(1, 4), access_load, priv_supervisor, 2);
    translate("nonleaf_l0", page_va(3, 0), access_load, priv_supervisor, 2);
    translate("store_read_only", page_va(1, 1), access_store, priv_supervisor, 2);
    translate("store_read_only_cached", page_va(1, 1), access_store, priv_supervisor, 0);
    translate("fetch_no_x", page_va(1, 0), access_fetch, priv_supervisor, 0);
    translate("user_on_s_page", page_va(1, 0), access_load, priv_user, 0);
    translate("s_on_u_page", page_va(1, 3), access_load, priv_supervisor, 2);
    sum = 1'b1;
    translate("s_on_u_page_sum", page_va(1, 3), access_load, priv_supervisor, 0);
    sum = 1'b0;
    translate("load_x_only", page_va(1, 2), access_load, priv_supervisor, 2);
    mxr = 1'b1;
    translate("load_x_only_mxr", page_va(1, 2), access_load, priv_supervisor, 0);
    mxr = 1'b0;

    // flushes
    flush_all_tlb();
    translate("after_flush_all_4k", page_va(1, 0), access_load, priv_supervisor, 2);
    translate("after_flush_all_mega", page_va(2, 10'($urandom)), access_load, priv_supervisor, 1);
    flush_tlb_page(page_va(1, 0));
    translate("flushed_page", page_va(1, 0), access_load, priv_supervisor, 2);
    translate("mega_kept", page_va(2, 10'($urandom)), access_load, priv_supervisor, 0);
    flush_tlb_page(page_va(2, 10'($urandom)));  // any vpn0 hits the whole megapage
    translate("flushed_megapage", page_va(2, 10'($urandom)), access_load, priv_supervisor, 1);

    // round robin over eight entries, nine pages
    flush_all_tlb();
    first_va = page_va(1, 5);
    for (int i = 5; i < 14; i++) begin
      translate("fill_page", page_va(1, 10'(i)), access_load, priv_supervisor, 2);
    end
    translate("evicted_first", first_va, access_load, priv_supervisor, 2);

    repeat (2) @(posedge clk);
    $display("closing: %0d response errors, %0d protocol errors", errors,
             dut_i.props_i.protocol_errors);
    if ((errors == 0) && (dut_i.props_i.protocol_errors == 0)) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // reset held over two rising edges, released just after the second
  initial begin
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset_n = 1'b1;
  end

endmodule

/* verilog/mmu_pkg.sv */
package mmu_pkg;

  // ============================================================
  // sv32 geometry
  // ============================================================
  localparam int page_shift      = 12;  // 4 KiB page offset
  localparam int vpn_width       = 20;  // vpn1 + vpn0
  localparam int vpn_part_width  = 10;  // one vpn level, also ppn0
  localparam int ppn_width       = 22;  // ppn1 + ppn0
  localparam int pte_bytes       = 4;   // table index stride
  localparam int tlb_entries     = 8;
  localparam int tlb_index_width = 3;

  // raw pte as read from memory
  typedef struct packed {
    logic [ppn_width-vpn_part_width-1:0] ppn1;  // 12 bits
    logic [vpn_part_width-1:0]           ppn0;
    logic [1:0]                          rsw;   // software bits, ignored
    logic                                d;
    logic                                a;
    logic                                g;
    logic                                u;
    logic                                x;
    logic                                w;
    logic                                r;
    logic                                v;
  } pte_t;

  typedef struct packed {
    logic                 mode;  // 1 = sv32
    logic [8:0]           asid;  // not used for tagging
    logic [ppn_width-1:0] ppn;   // root table
  } satp_t;

  typedef enum logic [1:0] {
    access_load,
    access_store,
    access_fetch
  } access_t;

  typedef enum logic [1:0] {
    priv_user       = 2'd0,
    priv_supervisor = 2'd1,
    priv_machine    = 2'd3
  } priv_t;

  typedef struct packed {
    logic [31:0] vaddr;
    access_t     access;
    priv_t       priv;
  } mmu_req_t;

  // low byte of the pte, same bit order
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_flags_t;

  typedef struct packed {
    logic [vpn_width-1:0] vpn;       // vpn0 zero for megapages
    logic [ppn_width-1:0] ppn;
    pte_flags_t           flags;
    logic                 megapage;  // leaf found at level 1
  } tlb_entry_t;

  typedef struct packed {
    logic       valid;
    tlb_entry_t entry;
  } tlb_fill_t;

  typedef enum logic [1:0] {
    walk_idle,
    walk_req_l1,
    walk_req_l0,
    walk_done
  } walk_state_t;

  // ============================================================
  // leaf permission check
  // ============================================================
  function automatic logic access_allowed(input pte_flags_t flags, input access_t access,
                                          input priv_t priv, input logic sum, input logic mxr);
    logic ok;
    ok = flags.v && (flags.r || flags.x);  // must be a valid leaf
    if (flags.w && !flags.r) ok = 1'b0;    // reserved encoding
    if ((priv == priv_user) && !flags.u) ok = 1'b0;
    if ((priv == priv_supervisor) && flags.u && !sum) ok = 1'b0;
    case (access)
      access_fetch: ok = ok && flags.x;
      access_store: ok = ok && flags.w;
      default:      ok = ok && (flags.r || (flags.x && mxr));  // load, mxr opens x pages
    endcase
    return ok;
  endfunction

endpackage

/* verilog/mmu_translator.sv */
`timescale 1ns/1ps

module mmu_translator (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          req_valid,
  input  mmu_pkg::mmu_req_t             req,
  input  mmu_pkg::satp_t                satp,
  input  logic                          sum,
  input  logic                          mxr,
  output logic                          resp_ready,
  output logic [31:0]                   resp_paddr,
  output logic                          resp_page_fault,
  output logic [31:0]                   resp_fault_vaddr,
  output logic [mmu_pkg::vpn_width-1:0] lookup_vpn,
  input  logic                          lookup_hit,
  input  mmu_pkg::tlb_entry_t           lookup_entry,
  output logic                          walk_start,
  output logic [31:0]                   walk_vaddr,
  output logic [mmu_pkg::ppn_width-1:0] walk_root_ppn,
  input  logic                          walk_done,
  input  logic                          walk_fault
);
  import mmu_pkg::*;

  typedef enum logic [1:0] {
    tr_idle,
    tr_wait_walk,
    tr_retry,
    tr_respond  // resp_ready cycle, req_valid ignored
  } tr_state_t;

  tr_state_t                       state;
  logic                            bare;
  logic                            allowed;
  logic                            respond_now;
  logic                            fault_now;
  logic                            need_walk;
  logic [31:0]                     paddr_now;
  logic [ppn_width+page_shift-1:0] pa_full;  // 34-bit physical address

  // req is held stable by the core until resp_ready
  assign lookup_vpn    = req.vaddr[31:page_shift];
  assign walk_vaddr    = req.vaddr;
  assign walk_root_ppn = satp.ppn;
  assign bare          = !satp.mode || (req.priv == priv_machine);
  assign allowed       = access_allowed(lookup_entry.flags, req.access, req.priv, sum, mxr);

  // ============================================================
  // physical address from the hit entry
  // ============================================================
  always_comb begin
    if (lookup_entry.megapage) begin
      // 4 MiB, ppn1 over the low 22 bits of the vaddr
      pa_full = {lookup_entry.ppn[ppn_width-1:vpn_part_width],
                 req.vaddr[page_shift+vpn_part_width-1:0]};
    end else begin
      pa_full = {lookup_entry.ppn, req.vaddr[page_shift-1:0]};
    end
  end

  // ============================================================
  // decide this cycle
  // ============================================================
  always_comb begin
    respond_now = 1'b0;
    fault_now   = 1'b0;
    need_walk   = 1'b0;
    paddr_now   = pa_full[31:0];
    case (state)
      tr_idle: begin
        if (req_valid && bare) begin
          respond_now = 1'b1;
          paddr_now   = req.vaddr;  // pa = va
        end else if (req_valid && lookup_hit) begin
          respond_now = 1'b1;
          fault_now   = !allowed;   // cached fault needs no walk
        end else if (req_valid) begin
          need_walk = 1'b1;
        end
      end
      tr_wait_walk: begin
        if (walk_done && walk_fault) begin
          respond_now = 1'b1;
          fault_now   = 1'b1;
        end
      end
      tr_retry: begin
        respond_now = lookup_hit;
        fault_now   = lookup_hit && !allowed;
        need_walk   = !lookup_hit;  // flushed meanwhile, walk again
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state           <= tr_idle;
      resp_ready      <= 1'b0;
      resp_page_fault <= 1'b0;
      walk_start      <= 1'b0;
    end else begin
      resp_ready      <= respond_now;
      resp_page_fault <= fault_now;
      walk_start      <= need_walk;  // walker starts next cycle
      if (respond_now) begin
        state <= tr_respond;
      end else if (need_walk) begin
        state <= tr_wait_walk;
      end else if ((state == tr_wait_walk) && walk_done) begin
        state <= tr_retry;          // entry filled, look up again
      end else if (state == tr_respond) begin
        state <= tr_idle;
      end
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (respond_now) begin
      resp_paddr       <= paddr_now;
      resp_fault_vaddr <= req.vaddr;
    end
  end

endmodule

/* verilog/page_table_walker.sv */
`timescale 1ns/1ps

module page_table_walker (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          walk_start,
  input  logic [31:0]                   walk_vaddr,
  input  logic [mmu_pkg::ppn_width-1:0] walk_root_ppn,
  output logic                          walk_done,
  output logic                          walk_fault,
  output mmu_pkg::tlb_fill_t            fill,
  output logic                          mem_req_valid,
  output logic [31:0]                   mem_req_addr,
  input  logic                          mem_resp_valid,
  input  mmu_pkg::pte_t                 mem_resp_data
);
  import mmu_pkg::*;

  walk_state_t               state;
  logic [31:0]               vaddr_q;     // address under walk
  logic [vpn_part_width-1:0] vpn0;
  logic                      leaf;
  logic                      resp_taken;  // response for the open read
  logic                      fill_valid;
  tlb_entry_t                fill_entry;

  // table base * 4096 + index * pte size, kept to 32 bits
  function automatic logic [31:0] pte_addr(input logic [ppn_width-1:0] ppn,
                                           input logic [vpn_part_width-1:0] idx);
    logic [ppn_width+page_shift-1:0] full;
    full = {ppn, {page_shift{1'b0}}} + (ppn_width + page_shift)'(idx * pte_bytes);
    return full[31:0];
  endfunction

  assign vpn0       = vaddr_q[page_shift +: vpn_part_width];
  assign leaf       = mem_resp_data.r || mem_resp_data.x;
  assign resp_taken = mem_req_valid && mem_resp_valid;
  assign fill       = '{valid: fill_valid, entry: fill_entry};

  // ============================================================
  // walk FSM
  // ============================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= walk_idle;
      mem_req_valid <= 1'b0;
      walk_done     <= 1'b0;
      walk_fault    <= 1'b0;
      fill_valid    <= 1'b0;
    end else begin
      walk_done  <= 1'b0;  // pulses
      fill_valid <= 1'b0;
      case (state)
        walk_idle: begin
          if (walk_start) begin
            state         <= walk_req_l1;
            mem_req_valid <= 1'b1;
          end
        end
        walk_req_l1, walk_req_l0: begin
          if (!mem_req_valid) begin
            mem_req_valid <= 1'b1;  // level-0 read, one idle cycle after level 1
          end else if (mem_resp_valid) begin
            mem_req_valid <= 1'b0;
            if (!mem_resp_data.v || (!leaf && (state == walk_req_l0))) begin
              walk_done  <= 1'b1;
              walk_fault <= 1'b1;  // no fill
              state      <= mmu_pkg::walk_done;
            end else if (leaf) begin
              fill_valid <= 1'b1;  // cached even if it denies the access
              walk_done  <= 1'b1;
              walk_fault <= 1'b0;
              state      <= mmu_pkg::walk_done;
            end else begin
              state <= walk_req_l0;  // pointer to next table
            end
          end
        end
        mmu_pkg::walk_done: state <= walk_idle;
        default:            state <= walk_idle;
      endcase
    end
  end

  // ============================================================
  // address and fill payload
  // ============================================================
  always_ff @(posedge clk) begin
    if ((state == walk_idle) && walk_start) begin
      vaddr_q      <= walk_vaddr;
      mem_req_addr <= pte_addr(walk_root_ppn, walk_vaddr[31 -: vpn_part_width]);
    end else if (resp_taken) begin
      mem_req_addr        <= pte_addr({mem_resp_data.ppn1, mem_resp_data.ppn0}, vpn0);
      fill_entry.vpn      <= vaddr_q[31:page_shift];
      fill_entry.ppn      <= {mem_resp_data.ppn1, mem_resp_data.ppn0};
      fill_entry.flags    <= pte_flags_t'(mem_resp_data[7:0]);
      fill_entry.megapage <= (state == walk_req_l1);
    end
  end

endmodule

/* verilog/sv32_mmu.sv */
`timescale 1ns/1ps

module sv32_mmu (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              req_valid,
  input  mmu_pkg::mmu_req_t req,
  output logic              resp_ready,
  output logic [31:0]       resp_paddr,
  output logic              resp_page_fault,
  output logic [31:0]       resp_fault_vaddr,
  input  mmu_pkg::satp_t    satp,
  input  logic              sum,
  input  logic              mxr,
  input  logic              tlb_flush_all,
  input  logic              tlb_flush_page,
  input  logic [31:0]       tlb_flush_vaddr,
  output logic              mem_req_valid,
  output logic [31:0]       mem_req_addr,
  input  logic              mem_resp_valid,
  input  mmu_pkg::pte_t     mem_resp_data
);
  import mmu_pkg::*;

  // ============================================================
  // internal links
  // ============================================================
  logic [vpn_width-1:0] lookup_vpn;
  logic                 lookup_hit;
  tlb_entry_t           lookup_entry;
  logic                 walk_start;
  logic [31:0]          walk_vaddr;
  logic [ppn_width-1:0] walk_root_ppn;
  logic                 walk_done;
  logic                 walk_fault;
  tlb_fill_t            fill;  // walker -> tlb

  mmu_translator translator_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .req_valid        (req_valid),
    .req              (req),
    .satp             (satp),
    .sum              (sum),
    .mxr              (mxr),
    .resp_ready       (resp_ready),
    .resp_paddr       (resp_paddr),
    .resp_page_fault  (resp_page_fault),
    .resp_fault_vaddr (resp_fault_vaddr),
    .lookup_vpn       (lookup_vpn),
    .lookup_hit       (lookup_hit),
    .lookup_entry     (lookup_entry),
    .walk_start       (walk_start),
    .walk_vaddr       (walk_vaddr),
    .walk_root_ppn    (walk_root_ppn),
    .walk_done        (walk_done),
    .walk_fault       (walk_fault)
  );

  tlb_array tlb_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .lookup_vpn      (lookup_vpn),
    .lookup_hit      (lookup_hit),
    .lookup_entry    (lookup_entry),
    .fill            (fill),
    .tlb_flush_all   (tlb_flush_all),
    .tlb_flush_page  (tlb_flush_page),
    .tlb_flush_vaddr (tlb_flush_vaddr)
  );

  page_table_walker walker_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .walk_start     (walk_start),
    .walk_vaddr     (walk_vaddr),
    .walk_root_ppn  (walk_root_ppn),
    .walk_done      (walk_done),
    .walk_fault     (walk_fault),
    .fill           (fill),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

endmodule

/* verilog/tlb_array.sv */
`timescale 1ns/1ps

module tlb_array (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic [mmu_pkg::vpn_width-1:0] lookup_vpn,
  output logic                          lookup_hit,
  output mmu_pkg::tlb_entry_t           lookup_entry,
  input  mmu_pkg::tlb_fill_t            fill,
  input  logic                          tlb_flush_all,
  input  logic                          tlb_flush_page,
  input  logic [31:0]                   tlb_flush_vaddr
);
  import mmu_pkg::*;

  tlb_entry_t                 tlb_q [tlb_entries];  // entry payload
  logic [tlb_entries-1:0]     valid;
  logic [tlb_entries-1:0]     next_valid;
  logic [tlb_entries-1:0]     hit_vec;
  logic [tlb_entries-1:0]     slot_fill;
  logic [tlb_entries-1:0]     flush_hit;
  logic [tlb_index_width-1:0] victim;               // round-robin pointer
  logic [vpn_width-1:0]       flush_vpn;
  tlb_entry_t                 fill_entry;

  // megapage entries only compare vpn1
  function automatic logic entry_matches(input tlb_entry_t e, input logic [vpn_width-1:0] vpn);
    logic upper_eq;
    upper_eq = (e.vpn[vpn_width-1:vpn_part_width] == vpn[vpn_width-1:vpn_part_width]);
    if (e.megapage) return upper_eq;
    return upper_eq && (e.vpn[vpn_part_width-1:0] == vpn[vpn_part_width-1:0]);
  endfunction

  assign flush_vpn = tlb_flush_vaddr[31:page_shift];

  // store megapages with vpn0 cleared
  always_comb begin
    fill_entry = fill.entry;
    if (fill.entry.megapage) fill_entry.vpn[vpn_part_width-1:0] = '0;
  end

  // ============================================================
  // lookup, fully associative
  // ============================================================
  always_comb begin
    lookup_entry = '0;
    for (int i = 0; i < tlb_entries; i++) begin
      hit_vec[i] = valid[i] && entry_matches(tlb_q[i], lookup_vpn);
      if (hit_vec[i]) lookup_entry = tlb_q[i];
    end
  end

  assign lookup_hit = |hit_vec;

  // ============================================================
  // fill and flush
  // ============================================================
  always_comb begin
    for (int i = 0; i < tlb_entries; i++) begin
      slot_fill[i] = fill.valid && (victim == tlb_index_width'(i));
      // flush checks the entry the slot holds after this cycle
      flush_hit[i] = tlb_flush_all ||
                     (tlb_flush_page &&
                      entry_matches(slot_fill[i] ? fill_entry : tlb_q[i], flush_vpn));
      next_valid[i] = (valid[i] || slot_fill[i]) && !flush_hit[i];  // flush wins
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid  <= '0;
      victim <= '0;
    end else begin
      valid <= next_valid;
      if (fill.valid) victim <= victim + 1'b1;  // advance on every fill
    end
  end

  always_ff @(posedge clk) begin
    if (fill.valid) tlb_q[victim] <= fill_entry;
  end

endmodule
